// File: verilog/host_map_pkg.sv
//**************************************************
// host port address map and the request types
// shared by the decoder and the region owners
//**************************************************
`default_nettype none

package host_map_pkg;

    typedef logic [31:0] word_t;
    typedef logic [11:0] host_addr_t;
    // word offset inside one 0x100-byte region
    typedef logic [5:0]  region_offset_t;

    typedef enum logic [1:0] {
        region_none,
        region_input,
        region_config,
        region_output
    } host_region_e;

    // region bases, anything from 0x300 up is unmapped
    localparam host_addr_t INPUT_BASE  = 12'h000;
    localparam host_addr_t CONFIG_BASE = 12'h100;
    localparam host_addr_t OUTPUT_BASE = 12'h200;

    // raw request as driven by the host
    typedef struct packed {
        logic       wr;
        logic       rd;
        host_addr_t addr;
        word_t      wdata;
    } host_req_t;

    // registered and decoded access
    typedef struct packed {
        logic           wr;
        logic           rd;
        host_region_e   region;
        region_offset_t offset;
        word_t          wdata;
    } host_acc_t;

endpackage

`default_nettype wire

// File: verilog/dma_cfg_pkg.sv
//**************************************************
// transfer configuration, control word layout and
// the command sent on the external memory port
//**************************************************
`default_nettype none

package dma_cfg_pkg;

    typedef enum logic [1:0] {
        mode_idle = 2'd0,
        mode_push = 2'd1,
        mode_pull = 2'd2
    } mode_e;

    // number of beats minus one
    typedef logic [7:0]  xfer_len_t;
    typedef logic [31:0] mem_addr_t;

    // control word fields
    localparam int MODE_LSB = 0;
    localparam int LEN_LSB  = 24;

    // configuration word indices in the config region
    localparam int CFG_CTRL = 0;
    localparam int CFG_SRC  = 1;
    localparam int CFG_DST  = 2;

    typedef struct packed {
        xfer_len_t len;
        mem_addr_t src_addr;
        mem_addr_t dst_addr;
    } dma_cfg_t;

    // write set for a push, clear for a pull
    typedef struct packed {
        logic      write;
        mem_addr_t addr;
        xfer_len_t len;
    } mem_cmd_t;

endpackage

`default_nettype wire

// File: verilog/host_decode.sv
//**************************************************
// registers each host strobe and splits the byte
// address into a region and a word offset
//**************************************************
`default_nettype none

module host_decode (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire host_map_pkg::host_req_t req,
    output host_map_pkg::host_acc_t acc
);

    host_map_pkg::host_region_e   region_d;
    host_map_pkg::host_region_e   region_q;
    host_map_pkg::region_offset_t offset_q;
    host_map_pkg::word_t          wdata_q;
    logic                         wr_q;
    logic                         rd_q;

    // region comes from the 256-byte page of the address
    always_comb begin
        case (req.addr[11:8])
            host_map_pkg::INPUT_BASE[11:8]:  region_d = host_map_pkg::region_input;
            host_map_pkg::CONFIG_BASE[11:8]: region_d = host_map_pkg::region_config;
            host_map_pkg::OUTPUT_BASE[11:8]: region_d = host_map_pkg::region_output;
            default:                         region_d = host_map_pkg::region_none;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_q <= 1'b0;
            rd_q <= 1'b0;
        end else begin
            wr_q <= req.wr;
            rd_q <= req.rd;
        end
    end

    always_ff @(posedge clk) begin
        region_q <= region_d;
        offset_q <= req.addr[7:2];
        wdata_q  <= req.wdata;
    end

    assign acc = '{wr: wr_q, rd: rd_q, region: region_q, offset: offset_q, wdata: wdata_q};

endmodule

`default_nettype wire

// File: verilog/cfg_regs.sv
//**************************************************
// control, source and destination words; a stored
// mode starts one transfer once the engine is idle
//**************************************************
`default_nettype none

module cfg_regs (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire host_map_pkg::host_acc_t acc,
    input  wire                      busy,
    output dma_cfg_pkg::dma_cfg_t    cfg,
    output logic                     start,
    output dma_cfg_pkg::mode_e       start_mode,
    output host_map_pkg::word_t      cfg_rdata
);

    host_map_pkg::word_t ctrl_q;
    host_map_pkg::word_t src_q;
    host_map_pkg::word_t dst_q;
    logic                cfg_wr;

    assign cfg_wr = acc.wr && (acc.region == host_map_pkg::region_config);

    assign start_mode = dma_cfg_pkg::mode_e'(
        ctrl_q[dma_cfg_pkg::MODE_LSB +: $bits(dma_cfg_pkg::mode_e)]);
    // a mode written while busy waits here until the engine is free
    assign start = (start_mode != dma_cfg_pkg::mode_idle) && !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q <= '0;
            src_q  <= '0;
            dst_q  <= '0;
        end else begin
            // engine takes the transfer at this edge, so drop the mode
            if (start) begin
                ctrl_q[dma_cfg_pkg::MODE_LSB +: $bits(dma_cfg_pkg::mode_e)] <=
                    dma_cfg_pkg::mode_idle;
            end
            // a host write in the same cycle wins
            if (cfg_wr) begin
                case (acc.offset)
                    dma_cfg_pkg::CFG_CTRL: ctrl_q <= acc.wdata;
                    dma_cfg_pkg::CFG_SRC:  src_q  <= acc.wdata;
                    dma_cfg_pkg::CFG_DST:  dst_q  <= acc.wdata;
                    default: ;
                endcase
            end
        end
    end

    assign cfg = '{
        len:      ctrl_q[dma_cfg_pkg::LEN_LSB +: $bits(dma_cfg_pkg::xfer_len_t)],
        src_addr: src_q,
        dst_addr: dst_q
    };

    // indices above the last live word read as zero
    always_comb begin
        case (acc.offset)
            dma_cfg_pkg::CFG_CTRL: cfg_rdata = ctrl_q;
            dma_cfg_pkg::CFG_SRC:  cfg_rdata = src_q;
            dma_cfg_pkg::CFG_DST:  cfg_rdata = dst_q;
            default:               cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/xfer_engine.sv
//**************************************************
// runs one push or pull transfer: command cycle,
// then len+1 beats against the local buffers
//**************************************************
`default_nettype none

module xfer_engine #(
    parameter int BUF_DEPTH = 32
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire dma_cfg_pkg::dma_cfg_t   cfg,
    input  wire                          start,
    input  wire dma_cfg_pkg::mode_e      start_mode,
    output logic [$clog2(BUF_DEPTH)-1:0] in_idx,
    input  wire host_map_pkg::word_t     in_word,
    output dma_cfg_pkg::mem_cmd_t        mem_cmd,
    output logic                         mem_cmd_valid,
    output host_map_pkg::word_t          mem_wdata,
    output logic                         mem_wvalid,
    output logic                         mem_wlast,
    input  wire host_map_pkg::word_t     mem_rdata,
    input  wire                          mem_rvalid,
    output logic                         out_we,
    output logic [$clog2(BUF_DEPTH)-1:0] out_idx,
    output host_map_pkg::word_t          out_word,
    output logic                         busy,
    output logic                         xfer_done
);

    localparam int IDX_W = $clog2(BUF_DEPTH);

    typedef enum logic [1:0] {
        st_idle,
        st_cmd,
        st_push,
        st_pull
    } state_e;

    state_e                 state;
    dma_cfg_pkg::dma_cfg_t  cfg_q;
    dma_cfg_pkg::mode_e     mode_q;
    dma_cfg_pkg::xfer_len_t count;
    logic                   is_push;
    logic                   beat;
    logic                   last_beat;

    assign is_push = (mode_q == dma_cfg_pkg::mode_push);

    // push beats run back to back, pull beats follow rvalid
    assign beat      = (state == st_push) || ((state == st_pull) && mem_rvalid);
    assign last_beat = beat && (count == cfg_q.len);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            mode_q    <= dma_cfg_pkg::mode_idle;
            count     <= '0;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state  <= st_cmd;
                        mode_q <= start_mode;
                        count  <= '0;
                    end
                end
                st_cmd: begin
                    state <= is_push ? st_push : st_pull;
                end
                default: begin
                    if (beat) begin
                        count <= count + 1'b1;
                    end
                    if (last_beat) begin
                        state     <= st_idle;
                        xfer_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    // transfer settings held for the whole transfer
    always_ff @(posedge clk) begin
        if ((state == st_idle) && start) begin
            cfg_q <= cfg;
        end
    end

    assign busy          = (state != st_idle);
    assign mem_cmd_valid = (state == st_cmd);
    assign mem_cmd = '{
        write: is_push,
        addr:  is_push ? cfg_q.dst_addr : cfg_q.src_addr,
        len:   cfg_q.len
    };

    // word index of the byte address plus beat count, wrapped to the buffer
    assign in_idx  = IDX_W'(((cfg_q.src_addr >> 2) + count) % BUF_DEPTH);
    assign out_idx = IDX_W'(((cfg_q.dst_addr >> 2) + count) % BUF_DEPTH);

    assign mem_wvalid = (state == st_push);
    assign mem_wlast  = mem_wvalid && last_beat;
    assign mem_wdata  = in_word;

    assign out_we   = (state == st_pull) && mem_rvalid;
    assign out_word = mem_rdata;

endmodule

`default_nettype wire

// File: verilog/local_buffers.sv
//**************************************************
// input and output buffers plus the registered
// read response for the host port
//**************************************************
`default_nettype none

module local_buffers #(
    parameter int BUF_DEPTH = 32
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire host_map_pkg::host_acc_t acc,
    input  wire host_map_pkg::word_t     cfg_rdata,
    input  wire [$clog2(BUF_DEPTH)-1:0]  in_idx,
    output host_map_pkg::word_t          in_word,
    input  wire                          out_we,
    input  wire [$clog2(BUF_DEPTH)-1:0]  out_idx,
    input  wire host_map_pkg::word_t     out_word,
    output host_map_pkg::word_t          host_rdata,
    output logic                         host_rvalid
);

    localparam int IDX_W = $clog2(BUF_DEPTH);

    host_map_pkg::word_t in_buf  [BUF_DEPTH];
    host_map_pkg::word_t out_buf [BUF_DEPTH];
    logic [IDX_W-1:0]    host_idx;
    host_map_pkg::word_t rd_mux;

    // region offset folded onto the buffer depth
    assign host_idx = IDX_W'(acc.offset % BUF_DEPTH);

    // host fills the input side, pull beats fill the output side
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BUF_DEPTH; i++) begin
                in_buf[i]  <= '0;
                out_buf[i] <= '0;
            end
        end else begin
            if (acc.wr && (acc.region == host_map_pkg::region_input)) begin
                in_buf[host_idx] <= acc.wdata;
            end
            if (out_we) begin
                out_buf[out_idx] <= out_word;
            end
        end
    end

    assign in_word = in_buf[in_idx];

    always_comb begin
        case (acc.region)
            host_map_pkg::region_input:  rd_mux = in_buf[host_idx];
            host_map_pkg::region_config: rd_mux = cfg_rdata;
            host_map_pkg::region_output: rd_mux = out_buf[host_idx];
            default:                     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            host_rvalid <= 1'b0;
        end else begin
            host_rvalid <= acc.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (acc.rd) begin
            host_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: verilog/dma_top.sv
//**************************************************
// DMA device top: host decode, configuration,
// transfer engine and local buffers
//**************************************************
`default_nettype none

module dma_top #(
    parameter int BUF_DEPTH = 32
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire host_map_pkg::host_req_t host_req,
    output host_map_pkg::word_t          host_rdata,
    output logic                         host_rvalid,
    output dma_cfg_pkg::mem_cmd_t        mem_cmd,
    output logic                         mem_cmd_valid,
    output host_map_pkg::word_t          mem_wdata,
    output logic                         mem_wvalid,
    output logic                         mem_wlast,
    input  wire host_map_pkg::word_t     mem_rdata,
    input  wire                          mem_rvalid,
    output logic                         busy,
    output logic                         xfer_done
);

    host_map_pkg::host_acc_t        acc;
    dma_cfg_pkg::dma_cfg_t          cfg;
    logic                           start;
    dma_cfg_pkg::mode_e             start_mode;
    host_map_pkg::word_t            cfg_rdata;
    logic [$clog2(BUF_DEPTH)-1:0]   in_idx;
    host_map_pkg::word_t            in_word;
    logic                           out_we;
    logic [$clog2(BUF_DEPTH)-1:0]   out_idx;
    host_map_pkg::word_t            out_word;

    host_decode host_decode_i (
        .clk (clk),
        .rst_n (rst_n),
        .req (host_req),
        .acc (acc)
    );

    cfg_regs cfg_regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc        (acc),
        .busy       (busy),
        .cfg        (cfg),
        .start      (start),
        .start_mode (start_mode),
        .cfg_rdata  (cfg_rdata)
    );

    xfer_engine #(
        .BUF_DEPTH (BUF_DEPTH)
    ) xfer_engine_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg           (cfg),
        .start         (start),
        .start_mode    (start_mode),
        .in_idx        (in_idx),
        .in_word       (in_word),
        .mem_cmd       (mem_cmd),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_wdata     (mem_wdata),
        .mem_wvalid    (mem_wvalid),
        .mem_wlast     (mem_wlast),
        .mem_rdata     (mem_rdata),
        .mem_rvalid    (mem_rvalid),
        .out_we        (out_we),
        .out_idx       (out_idx),
        .out_word      (out_word),
        .busy          (busy),
        .xfer_done     (xfer_done)
    );

    local_buffers #(
        .BUF_DEPTH (BUF_DEPTH)
    ) local_buffers_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .acc         (acc),
        .cfg_rdata   (cfg_rdata),
        .in_idx      (in_idx),
        .in_word     (in_word),
        .out_we      (out_we),
        .out_idx     (out_idx),
        .out_word    (out_word),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid)
    );

endmodule

`default_nettype wire

// File: tests/dma_props.sv
//**************************************************
// protocol properties on the dma_top ports, bound
// into the DUT from the testbench side
//**************************************************
`default_nettype none

module dma_props (
    input wire                          clk,
    input wire                          rst_n,
    input wire host_map_pkg::host_req_t host_req,
    input wire                          host_rvalid,
    input wire                          mem_cmd_valid,
    input wire                          mem_wvalid,
    input wire                          mem_wlast,
    input wire                          busy,
    input wire                          xfer_done
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    beats_inside_transfer: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_wvalid || mem_wlast) |-> busy)
        else begin
            $error("write beat outside a transfer");
            fail_count++;
        end

    cmd_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        mem_cmd_valid |=> !mem_cmd_valid)
        else begin
            $error("mem_cmd_valid held longer than one cycle");
            fail_count++;
        end

    done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        xfer_done |=> !xfer_done)
        else begin
            $error("xfer_done held longer than one cycle");
            fail_count++;
        end

    // read response latency, both directions
    read_gives_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        host_req.rd |-> ##2 host_rvalid)
        else begin
            $error("host_rvalid not two cycles after a read strobe");
            fail_count++;
        end

    rvalid_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
        host_rvalid |-> $past(host_req.rd, 2))
        else begin
            $error("host_rvalid without a read strobe two cycles earlier");
            fail_count++;
        end

endmodule

bind dma_top dma_props props_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_req      (host_req),
    .host_rvalid   (host_rvalid),
    .mem_cmd_valid (mem_cmd_valid),
    .mem_wvalid    (mem_wvalid),
    .mem_wlast     (mem_wlast),
    .busy          (busy),
    .xfer_done     (xfer_done)
);

`default_nettype wire

// File: tests/dma_tb.sv
//**************************************************
// testbench for dma_top: replays the trace file,
// models the external memory and checks results
//**************************************************
`default_nettype none

module dma_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BUF_DEPTH       = 32;
    localparam int CYCLES_PER_LINE = 300;
    localparam host_map_pkg::host_addr_t CTRL_ADDR =
        host_map_pkg::CONFIG_BASE + 12'(4 * dma_cfg_pkg::CFG_CTRL);
    localparam host_map_pkg::host_addr_t SRC_ADDR =
        host_map_pkg::CONFIG_BASE + 12'(4 * dma_cfg_pkg::CFG_SRC);
    localparam host_map_pkg::host_addr_t DST_ADDR =
        host_map_pkg::CONFIG_BASE + 12'(4 * dma_cfg_pkg::CFG_DST);

    logic                    clk;
    logic                    rst_n;
    host_map_pkg::host_req_t host_req;
    host_map_pkg::word_t     host_rdata;
    logic                    host_rvalid;
    dma_cfg_pkg::mem_cmd_t   mem_cmd;
    logic                    mem_cmd_valid;
    host_map_pkg::word_t     mem_wdata;
    logic                    mem_wvalid;
    logic                    mem_wlast;
    host_map_pkg::word_t     mem_rdata;
    logic                    mem_rvalid;
    logic                    busy;
    logic                    xfer_done;

    host_map_pkg::word_t beats [256];
    logic [31:0]         lfsr_state;
    logic [31:0]         src_shadow;
    logic [31:0]         dst_shadow;
    int                  trace_lines;
    int                  err_count;
    int                  cmd_seen;
    int                  cmd_expected;

    dma_top #(
        .BUF_DEPTH (BUF_DEPTH)
    ) dma_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .host_req      (host_req),
        .host_rdata    (host_rdata),
        .host_rvalid   (host_rvalid),
        .mem_cmd       (mem_cmd),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_wdata     (mem_wdata),
        .mem_wvalid    (mem_wvalid),
        .mem_wlast     (mem_wlast),
        .mem_rdata     (mem_rdata),
        .mem_rvalid    (mem_rvalid),
        .busy          (busy),
        .xfer_done     (xfer_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // every command pulse the DUT issues, expected or not
    always @(negedge clk) begin
        if (rst_n && mem_cmd_valid) begin
            cmd_seen++;
        end
    end

    initial begin
        wait (trace_lines > 0);
        repeat (16 + trace_lines * CYCLES_PER_LINE) @(posedge clk);
        $display("watchdog expired, the trace did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // galois form, x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 32'hd000_0001;
        end
        return nxt;
    endfunction

    task automatic take_random_bit(output logic b);
        b          = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    function automatic host_map_pkg::word_t control_word(input dma_cfg_pkg::mode_e mode,
                                                         input dma_cfg_pkg::xfer_len_t len);
        host_map_pkg::word_t w;
        w = '0;
        w[dma_cfg_pkg::LEN_LSB +: 8]  = len;
        w[dma_cfg_pkg::MODE_LSB +: 2] = mode;
        return w;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            err_count++;
        end
    endtask

    // all host tasks start and end on a falling edge
    task automatic host_write(input host_map_pkg::host_addr_t addr,
                              input host_map_pkg::word_t data);
        host_req = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        @(negedge clk);
        host_req.wr = 1'b0;
        if (addr == SRC_ADDR) src_shadow = data;
        if (addr == DST_ADDR) dst_shadow = data;
    endtask

    task automatic host_read(input host_map_pkg::host_addr_t addr,
                             input host_map_pkg::word_t exp);
        host_req = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: '0};
        @(negedge clk);
        host_req.rd = 1'b0;
        @(negedge clk);
        assert (host_rvalid) else begin
            $display("host_rvalid missing two cycles after the read of %h", addr);
            err_count++;
        end
        compare_word("host_rdata", host_rdata, exp);
        assert (!busy) else begin
            $display("device still busy during the host read of %h", addr);
            err_count++;
        end
    endtask

    task automatic wait_command(input logic write, input dma_cfg_pkg::xfer_len_t len,
                                output logic found);
        found = 1'b0;
        for (int i = 0; i < 16 && !found; i++) begin
            @(negedge clk);
            found = mem_cmd_valid;
        end
        assert (found) else begin
            $display("no memory command after the control word write");
            err_count++;
        end
        if (found) begin
            cmd_expected++;
            assert (busy) else begin
                $display("busy low while the memory command is issued");
                err_count++;
            end
            compare_word("mem_cmd.write", mem_cmd.write, write);
            compare_word("mem_cmd.addr", mem_cmd.addr, write ? dst_shadow : src_shadow);
            compare_word("mem_cmd.len", mem_cmd.len, len);
        end
    endtask

    task automatic check_done();
        assert (xfer_done && !busy) else begin
            $display("xfer_done missing or busy still high one cycle after the last beat");
            err_count++;
        end
    endtask

    task automatic run_push(input dma_cfg_pkg::xfer_len_t len);
        logic found;
        host_write(CTRL_ADDR, control_word(dma_cfg_pkg::mode_push, len));
        wait_command(1'b1, len, found);
        if (found) begin
            for (int k = 0; k <= len; k++) begin
                @(negedge clk);
                assert (mem_wvalid) else begin
                    $display("mem_wvalid low at push beat %0d", k);
                    err_count++;
                end
                compare_word("mem_wdata", mem_wdata, beats[k]);
                compare_word("mem_wlast", mem_wlast, k == len);
            end
            @(negedge clk);
            check_done();
        end
    endtask

    // read beats with 0 to 3 idle cycles before each
    task automatic run_pull(input dma_cfg_pkg::xfer_len_t len);
        logic       found;
        logic       b0;
        logic       b1;
        logic [1:0] gap;
        host_write(CTRL_ADDR, control_word(dma_cfg_pkg::mode_pull, len));
        wait_command(1'b0, len, found);
        if (found) begin
            @(negedge clk);
            for (int k = 0; k <= len; k++) begin
                take_random_bit(b0);
                take_random_bit(b1);
                gap = {b1, b0};
                repeat (gap) @(negedge clk);
                mem_rvalid = 1'b1;
                mem_rdata  = beats[k];
                @(negedge clk);
                mem_rvalid = 1'b0;
                mem_rdata  = '0;
            end
            check_done();
        end
    endtask

    initial begin
        int          fd;
        int          code;
        int          test_count;
        int          test_fail;
        int          errs_before;
        string       op;
        string       rest;
        logic [31:0] a;
        logic [31:0] d;

        host_req     = '0;
        mem_rdata    = '0;
        mem_rvalid   = 1'b0;
        rst_n        = 1'b0;
        lfsr_state   = 32'h2f3b_5f7d;
        src_shadow   = '0;
        dst_shadow   = '0;
        trace_lines  = 0;
        err_count    = 0;
        cmd_seen     = 0;
        cmd_expected = 0;
        test_count   = 0;
        test_fail    = 0;

        // first pass only sizes the watchdog
        fd = $fopen("tests/dma_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file tests/dma_trace.txt");
            err_count++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(rest, fd);
                if (code > 0) trace_lines++;
            end
            $fclose(fd);
            fd = $fopen("tests/dma_trace.txt", "r");
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        while (fd != 0 && !$feof(fd)) begin
            code = $fscanf(fd, "%s", op);
            if (code == 1 && op == "#") begin
                code = $fgets(rest, fd);
            end else if (code == 1) begin
                errs_before = err_count;
                if (op == "W") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    host_write(a[11:0], d);
                end else if (op == "R") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    host_read(a[11:0], d);
                end else if (op == "P" || op == "L") begin
                    code = $fscanf(fd, "%h", a);
                    for (int k = 0; k <= a[7:0]; k++) begin
                        code = $fscanf(fd, "%h", beats[k]);
                    end
                    if (op == "P") run_push(a[7:0]);
                    else run_pull(a[7:0]);
                end else begin
                    $display("unknown trace operation %s", op);
                    err_count++;
                end
                test_count++;
                if (err_count != errs_before) test_fail++;
                $display("test %0d %s %s", test_count, op,
                         (err_count == errs_before) ? "ok" : "failed");
            end
        end
        if (fd != 0) $fclose(fd);

        repeat (4) @(negedge clk);
        assert (cmd_seen == cmd_expected) else begin
            $display("%0d memory commands seen, %0d expected", cmd_seen, cmd_expected);
            err_count++;
        end
        assert (dma_top_i.props_i.fail_count == 0) else begin
            $display("%0d bound property failures", dma_top_i.props_i.fail_count);
            err_count++;
        end
        $display("%0d tests, %0d failed, %0d check errors", test_count, test_fail, err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/dma_trace.txt
# op args in hex: W addr data, R addr expected, P len expected push beats, L len pull beats
# P and L write the control word themselves, then run one transfer
W 000 11110000
W 004 22220001
W 008 33330002
W 00c 44440003
R 004 22220001
R 100 00000000
W 108 000a0000
R 108 000a0000
R 114 00000000
R 300 00000000
P 3 11110000 22220001 33330002 44440003
R 100 03000000
W 078 5555001e
W 07c 6666001f
W 104 00000078
P 3 5555001e 6666001f 11110000 22220001
W 108 00000010
L 2 a0a0a0a0 b1b1b1b1 c2c2c2c2
R 210 a0a0a0a0
R 218 c2c2c2c2
W 108 0000007c
L 2 d3d3d3d3 e4e4e4e4 f5f5f5f5
R 27c d3d3d3d3
R 200 e4e4e4e4
R 204 f5f5f5f5
R 100 02000000

// File: tb.f
verilog/host_map_pkg.sv
verilog/dma_cfg_pkg.sv
verilog/host_decode.sv
verilog/cfg_regs.sv
verilog/xfer_engine.sv
verilog/local_buffers.sv
verilog/dma_top.sv
tests/dma_props.sv
tests/dma_tb.sv
